/* run.sh */
#!/usr/bin/env bash
# Build the keypad testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module keypad_tb --Mdir "$OBJ" -o keypad_sim -f tb.f; then
    echo "Build failed"
    exit 1
fi

# Raise the error limit so the testbench reports assertion failures itself
"./$OBJ/keypad_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi
echo "PASS"
exit 0

/* src/column_scanner.sv */
module column_scanner
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                nRST,
    input  logic [NUM_ROWS-1:0] row,
    output logic [NUM_COLS-1:0] col,
    output logic [COL_W-1:0]    scan_col,
    output logic                sample_valid,
    output logic [NUM_ROWS-1:0] sample_rows
);

    localparam int DWELL_W = $clog2(SCAN_DWELL);

    logic [DWELL_W-1:0] dwell_cnt;
    logic               dwell_end;

    assign dwell_end    = (dwell_cnt == DWELL_W'(SCAN_DWELL - 1));
    assign sample_valid = dwell_end;  // Last clock of the dwell

    // Dwell and column counters
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            dwell_cnt <= '0;
            scan_col  <= '0;
        end else if (dwell_end) begin
            dwell_cnt <= '0;
            scan_col  <= scan_col + 1'b1;  // Wraps after last column
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Column drive trails scan_col by one clock
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col <= '1;  // Nothing driven in reset
        end else begin
            col <= ~(NUM_COLS'(1) << scan_col);
        end
    end

    // The rows settle in the second clock of the dwell. By the last
    // clock this register holds a clean copy for the current column.
    always_ff @(posedge clk) begin
        sample_rows <= ~row;  // 1 means pressed
    end

endmodule

/* src/key_debouncer.sv */
module key_debouncer
    import keypad_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    input  logic sample_en,
    input  logic raw,
    output logic stable
);

    localparam int CNT_W = $clog2(DEBOUNCE_SAMPLES + 1);

    logic [CNT_W-1:0] diff_cnt;   // Consecutive disagreeing samples
    logic [CNT_W-1:0] cnt_next;

    assign cnt_next = diff_cnt + 1'b1;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            stable   <= 1'b0;
            diff_cnt <= '0;
        end else if (sample_en) begin
            if (raw == stable) begin
                diff_cnt <= '0;  // Bounce back, start over
            end else if (cnt_next == CNT_W'(DEBOUNCE_SAMPLES)) begin
                stable   <= raw;
                diff_cnt <= '0;
            end else begin
                diff_cnt <= cnt_next;
            end
        end
    end

endmodule

/* src/key_encoder.sv */
module key_encoder
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                nRST,
    input  logic [NUM_KEYS-1:0] key_stable,
    output logic                ev_valid,
    output key_event_t          ev_data
);

    logic [NUM_KEYS-1:0] prev_stable;
    logic [NUM_KEYS-1:0] rose;
    logic [KEY_W-1:0]    first_key;

    assign rose = key_stable & ~prev_stable;  // New presses only

    // Lowest-numbered rising key wins, the rest are dropped
    always_comb begin
        first_key = '0;
        for (int i = NUM_KEYS - 1; i >= 0; i--) begin
            if (rose[i]) begin
                first_key = KEY_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            prev_stable <= '0;
            ev_valid    <= 1'b0;
        end else begin
            prev_stable <= key_stable;
            ev_valid    <= |rose;  // One clock per new press
        end
    end

    // Event payload, qualified by ev_valid
    always_ff @(posedge clk) begin
        if (|rose) begin
            ev_data <= KEY_MAP[first_key];
        end
    end

endmodule

/* src/key_event_regs.sv */
module key_event_regs
    import keypad_pkg::*, wb_pkg::*;
(
    input  logic             clk,
    input  logic             nRST,
    input  logic             ev_valid,
    input  key_event_t       ev_data,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [WB_AW-1:0] wb_adr,
    input  logic [WB_DW-1:0] wb_dat_w,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic             wb_ack
);

    key_event_t evq [EVQ_DEPTH];

    logic [EVQ_AW-1:0] wr_ptr;
    logic [EVQ_AW-1:0] rd_ptr;
    logic [EVQ_CW-1:0] count;
    logic              ovf;

    logic              req;
    logic              rd_req;
    logic              clr_req;
    logic              empty;
    logic              full;
    logic              push;
    logic              pop;
    logic [WB_DW-1:0]  status_word;

    // New request only when no ack is pending
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign rd_req  = req && !wb_we;
    // Write data is ignored for CLEAR
    assign clr_req = req && wb_we && (wb_adr == REG_CLEAR);

    assign empty = (count == '0);
    assign full  = (count == EVQ_CW'(EVQ_DEPTH));
    assign push  = ev_valid && !full;  // Full queue drops the event
    assign pop   = rd_req && (wb_adr == REG_EVENT) && !empty;

    always_comb begin
        status_word = '0;
        status_word[STAT_CNT_MSB:STAT_CNT_LSB] = count;
        status_word[STAT_OVF_BIT] = ovf;
    end

    // Queue pointers, count and overflow flag
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
            if (ev_valid && full) begin
                ovf <= 1'b1;  // Set wins over clear
            end else if (clr_req) begin
                ovf <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            evq[wr_ptr] <= ev_data;
        end
    end

    // Single-cycle ack
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            case (wb_adr)
                REG_STATUS: wb_dat_r <= status_word;
                REG_EVENT:  wb_dat_r <= empty ? '0 : evq[rd_ptr];  // Empty reads 0
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

/* src/keypad_pkg.sv */
package keypad_pkg;

    localparam int NUM_COLS         = 4;
    localparam int NUM_ROWS         = 4;
    localparam int NUM_KEYS         = NUM_COLS * NUM_ROWS;
    localparam int COL_W            = $clog2(NUM_COLS);
    localparam int KEY_W            = $clog2(NUM_KEYS);
    localparam int SCAN_DWELL       = 4;  // Clocks per column
    localparam int DEBOUNCE_SAMPLES = 3;  // Equal samples needed to flip

    typedef enum logic {
        KIND_DIGIT,
        KIND_FUNC
    } key_kind_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_NEG,
        OP_EQUAL,
        OP_CLEAR
    } op_code_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [2:0] spare;
        logic [3:0] value;   // 0 to 9
    } digit_view_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] spare;
        op_code_t   op;
    } func_view_t;

    // Kind bit sits at bit 7 in both views
    typedef union packed {
        digit_view_t digit;
        func_view_t  func;
    } key_event_t;

    function automatic key_event_t digit_ev(logic [3:0] value);
        key_event_t ev;
        ev = '0;
        ev.digit.kind  = KIND_DIGIT;
        ev.digit.value = value;
        return ev;
    endfunction

    function automatic key_event_t func_ev(op_code_t op);
        key_event_t ev;
        ev = '0;
        ev.func.kind = KIND_FUNC;
        ev.func.op   = op;
        return ev;
    endfunction

    // Index is column * 4 + row
    localparam key_event_t KEY_MAP [NUM_KEYS] = '{
        digit_ev(4'd1), digit_ev(4'd4), digit_ev(4'd7), func_ev(OP_EQUAL),  // '*' is equal
        digit_ev(4'd2), digit_ev(4'd5), digit_ev(4'd8), digit_ev(4'd0),
        digit_ev(4'd3), digit_ev(4'd6), digit_ev(4'd9), func_ev(OP_CLEAR),  // '#' is clear
        func_ev(OP_ADD), func_ev(OP_SUB), func_ev(OP_MUL), func_ev(OP_NEG)
    };

endpackage

/* src/keypad_top.sv */
module keypad_top
    import keypad_pkg::*, wb_pkg::*;
(
    input  logic                clk,
    input  logic                nRST,
    input  logic [NUM_ROWS-1:0] row,
    output logic [NUM_COLS-1:0] col,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_AW-1:0]    wb_adr,
    input  logic [WB_DW-1:0]    wb_dat_w,
    output logic [WB_DW-1:0]    wb_dat_r,
    output logic                wb_ack
);

    logic                sample_valid;
    logic [COL_W-1:0]    scan_col;
    logic [NUM_ROWS-1:0] sample_rows;
    logic [NUM_KEYS-1:0] key_stable;
    logic                ev_valid;
    key_event_t          ev_data;

    column_scanner u_scanner (
        .clk          (clk),
        .nRST         (nRST),
        .row          (row),
        .col          (col),
        .scan_col     (scan_col),
        .sample_valid (sample_valid),
        .sample_rows  (sample_rows)
    );

    // One cell per key, fed only while its column is sampled
    for (genvar i = 0; i < NUM_KEYS; i++) begin : g_key
        localparam logic [COL_W-1:0] KEY_COL = COL_W'(i / NUM_ROWS);

        key_debouncer u_deb (
            .clk       (clk),
            .nRST      (nRST),
            .sample_en (sample_valid && (scan_col == KEY_COL)),
            .raw       (sample_rows[i % NUM_ROWS]),
            .stable    (key_stable[i])
        );
    end

    key_encoder u_encoder (
        .clk        (clk),
        .nRST       (nRST),
        .key_stable (key_stable),
        .ev_valid   (ev_valid),
        .ev_data    (ev_data)
    );

    key_event_regs u_regs (
        .clk      (clk),
        .nRST     (nRST),
        .ev_valid (ev_valid),
        .ev_data  (ev_data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

    localparam int WB_DW = 8;
    localparam int WB_AW = 2;

    // Register map, word addresses
    localparam logic [WB_AW-1:0] REG_STATUS = 2'd0;
    localparam logic [WB_AW-1:0] REG_EVENT  = 2'd1;  // Read pops the head
    localparam logic [WB_AW-1:0] REG_CLEAR  = 2'd2;  // Any write clears overflow

    // STATUS fields
    localparam int STAT_CNT_LSB = 0;
    localparam int STAT_CNT_MSB = 2;
    localparam int STAT_OVF_BIT = 7;

    localparam int EVQ_DEPTH = 4;
    localparam int EVQ_AW    = $clog2(EVQ_DEPTH);
    localparam int EVQ_CW    = $clog2(EVQ_DEPTH + 1);

endpackage

/* tb.f */
src/keypad_pkg.sv
src/wb_pkg.sv
src/column_scanner.sv
src/key_debouncer.sv
src/key_encoder.sv
src/key_event_regs.sv
src/keypad_top.sv
tb/keypad_checker.sv
tb/keypad_tb.sv

/* tb/keypad_checker.sv */
module keypad_checker
    import keypad_pkg::*;
(
    input logic                clk,
    input logic                nRST,
    input logic [NUM_COLS-1:0] col,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;  // Watched by the testbench

    ack_follows_req: assert property (@(posedge clk) disable iff (!nRST)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("wb_ack high without a request in the previous cycle");
            assert_fails++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!nRST)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for two cycles in a row");
            assert_fails++;
        end

    // Idle is all ones, scanning drives exactly one column low
    col_one_low: assert property (@(posedge clk) disable iff (!nRST)
        $countones(~col) <= 1)
        else begin
            $error("More than one column driven low");
            assert_fails++;
        end

endmodule

bind keypad_top keypad_checker i_checker (
    .clk    (clk),
    .nRST   (nRST),
    .col    (col),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

/* tb/keypad_tb.sv */
module keypad_tb
    import keypad_pkg::*, wb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROUND_CLKS = NUM_COLS * SCAN_DWELL;  // One full scan
    localparam int ROW_W      = $clog2(NUM_ROWS);
    localparam int NUM_STEPS  = 25;
    // Per step up to 2 bounce, 4 press, 4 hold and 4 release rounds
    localparam int TIMEOUT_CYCLES = (NUM_STEPS * 14 + 4) * ROUND_CLKS * 2;

    typedef struct packed {
        logic [KEY_W-1:0]  key;
        key_event_t        ev;
        logic [EVQ_CW-1:0] cnt;     // Queue count after the press
        logic              ovf;
        logic              bounce;
        logic              hold;
        logic              drain;   // Read back all queued events afterwards
    } step_t;

    // Bit 7 is the kind, digit value in bits 3:0
    function automatic key_event_t digit_event(logic [3:0] value);
        return key_event_t'({KIND_DIGIT, 3'b000, value});
    endfunction

    // Bit 7 is the kind, operator code in bits 2:0
    function automatic key_event_t op_event(op_code_t op);
        return key_event_t'({KIND_FUNC, 4'b0000, op});
    endfunction

    // key, event, count, ovf, bounce, hold, drain
    localparam step_t STEPS [NUM_STEPS] = '{
        '{4'd0,  digit_event(4'd1), 3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd4,  digit_event(4'd2), 3'd2, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd8,  digit_event(4'd3), 3'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd1,  digit_event(4'd4), 3'd4, 1'b0, 1'b0, 1'b0, 1'b1},
        '{4'd5,  digit_event(4'd5), 3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd9,  digit_event(4'd6), 3'd2, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd2,  digit_event(4'd7), 3'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd6,  digit_event(4'd8), 3'd4, 1'b0, 1'b0, 1'b0, 1'b1},
        '{4'd10, digit_event(4'd9), 3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd7,  digit_event(4'd0), 3'd2, 1'b0, 1'b0, 1'b0, 1'b1},
        '{4'd12, op_event(OP_ADD),   3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd13, op_event(OP_SUB),   3'd2, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd14, op_event(OP_MUL),   3'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd15, op_event(OP_NEG),   3'd4, 1'b0, 1'b0, 1'b0, 1'b1},
        '{4'd3,  op_event(OP_EQUAL), 3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd11, op_event(OP_CLEAR), 3'd2, 1'b0, 1'b0, 1'b0, 1'b1},
        '{4'd5,  digit_event(4'd5), 3'd1, 1'b0, 1'b1, 1'b0, 1'b0},
        '{4'd13, op_event(OP_SUB),   3'd2, 1'b0, 1'b1, 1'b0, 1'b0},
        '{4'd0,  digit_event(4'd1), 3'd3, 1'b0, 1'b1, 1'b1, 1'b0},  // Held, no repeat
        '{4'd0,  digit_event(4'd1), 3'd4, 1'b0, 1'b1, 1'b0, 1'b1},
        '{4'd8,  digit_event(4'd3), 3'd1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd14, op_event(OP_MUL),   3'd2, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd3,  op_event(OP_EQUAL), 3'd3, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd9,  digit_event(4'd6), 3'd4, 1'b0, 1'b0, 1'b0, 1'b0},
        '{4'd15, op_event(OP_NEG),   3'd4, 1'b1, 1'b0, 1'b0, 1'b1}   // Dropped
    };

    logic                clk = 1'b0;
    logic                nRST;
    logic [NUM_ROWS-1:0] row;
    logic [NUM_COLS-1:0] col;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_AW-1:0]    wb_adr;
    logic [WB_DW-1:0]    wb_dat_w;
    logic [WB_DW-1:0]    wb_dat_r;
    logic                wb_ack;

    logic                key_down;
    logic [KEY_W-1:0]    key_sel;
    key_event_t          exp_q [$];  // Events expected in the queue
    int                  cycle_cnt = 0;

    keypad_top i_dut (
        .clk      (clk),
        .nRST     (nRST),
        .row      (row),
        .col      (col),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #20 clk = ~clk;

    // Pressed key shorts its row to its column
    always_comb begin
        row = '1;
        if (key_down && !col[key_sel[KEY_W-1:ROW_W]]) begin
            row[key_sel[ROW_W-1:0]] = 1'b0;
        end
    end

    task automatic fail_now();
        $display("Errors found");
        $fatal(1, "Run stopped on the first failure");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (i_dut.i_checker.assert_fails != 0) begin
            $display("A bus or column assertion failed");
            fail_now();
        end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_now();
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;  // Drive point after the edge
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do tick(1); while (!wb_ack);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        tick(1);
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do tick(1); while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        tick(1);
    endtask

    task automatic check_event(input key_event_t got, input key_event_t exp);
        if (got !== exp) begin
            $display("Error: time %0d ns, signal wb_dat_r (event), got %02h, expected %02h",
                     $time, got, exp);
            fail_now();
        end
    endtask

    task automatic check_status(input logic [EVQ_CW-1:0] got_cnt, input logic got_ovf,
                                input logic [EVQ_CW-1:0] exp_cnt, input logic exp_ovf);
        if (got_cnt !== exp_cnt) begin
            $display("Error: time %0d ns, signal wb_dat_r (status count), got %0d, expected %0d",
                     $time, got_cnt, exp_cnt);
            fail_now();
        end
        if (got_ovf !== exp_ovf) begin
            $display("Error: time %0d ns, signal wb_dat_r (overflow), got %b, expected %b",
                     $time, got_ovf, exp_ovf);
            fail_now();
        end
    endtask

    task automatic read_status(output logic [EVQ_CW-1:0] cnt, output logic ovf);
        logic [WB_DW-1:0] d;
        wb_read(REG_STATUS, d);
        cnt = d[STAT_CNT_MSB:STAT_CNT_LSB];
        ovf = d[STAT_OVF_BIT];
    endtask

    // Poll until the press shows up
    task automatic wait_status(input logic [EVQ_CW-1:0] exp_cnt, input logic exp_ovf);
        logic [EVQ_CW-1:0] cnt;
        logic              ovf;
        do read_status(cnt, ovf); while (cnt !== exp_cnt || ovf !== exp_ovf);
    endtask

    task automatic drain_events(input logic exp_ovf);
        logic [WB_DW-1:0]  d;
        logic [EVQ_CW-1:0] cnt;
        logic              ovf;
        key_event_t        exp;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            wb_read(REG_EVENT, d);
            check_event(key_event_t'(d), exp);
        end
        wb_read(REG_EVENT, d);  // Empty queue reads 0
        check_event(key_event_t'(d), '0);
        read_status(cnt, ovf);
        check_status(cnt, ovf, '0, exp_ovf);
        if (exp_ovf) begin
            wb_write(REG_CLEAR, 8'hA5);
            read_status(cnt, ovf);
            check_status(cnt, ovf, '0, 1'b0);
        end
    endtask

    task automatic run_step(input step_t st);
        int                halves;
        logic [EVQ_CW-1:0] cnt;
        logic              ovf;
        key_sel = st.key;
        if (st.bounce) begin
            // Each bounce phase spans one sample of the key
            halves = int'($urandom_range(0, 2));  // Up to 2 scan rounds
            for (int i = 0; i < halves; i++) begin
                key_down = (i % 2 == 0);
                tick(ROUND_CLKS);
            end
        end
        key_down = 1'b1;
        wait_status(st.cnt, st.ovf);
        if (exp_q.size() < EVQ_DEPTH) begin
            exp_q.push_back(st.ev);
        end
        if (st.hold) begin
            tick(4 * ROUND_CLKS);
            read_status(cnt, ovf);
            check_status(cnt, ovf, st.cnt, st.ovf);
        end
        key_down = 1'b0;
        tick(4 * ROUND_CLKS);
        read_status(cnt, ovf);  // Release adds nothing
        check_status(cnt, ovf, st.cnt, st.ovf);
        if (st.drain) begin
            drain_events(st.ovf);
        end
    endtask

    initial begin
        logic [WB_DW-1:0]  d;
        logic [EVQ_CW-1:0] cnt;
        logic              ovf;
        void'($urandom(75));
        nRST     = 1'b0;
        key_down = 1'b0;
        key_sel  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        tick(2);
        nRST = 1'b1;
        tick(1);

        read_status(cnt, ovf);
        check_status(cnt, ovf, '0, 1'b0);
        wb_read(REG_EVENT, d);
        check_event(key_event_t'(d), '0);

        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(STEPS[i]);
        end
        tick(2);

        $display("No errors");
        $finish;
    end

endmodule
